/* Bender.yml */
package:
  name: memory_bus

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/membus_pkg.sv
      - common/bank_if.sv
      - hw/memory_bus/mem_decode.sv
      - hw/memory_bus/bank_sram.sv
      - hw/memory_bus/read_align.sv
      - hw/memory_bus/memory_bus.sv
      - target: test
        files:
          - tb/tb_memory_bus.sv

/* common/bank_if.sv */
// bank lane interface.
// carries the split request from the decoder to the even and odd banks.

`timescale 1ns/1ps

`include "membus_settings.svh"

interface bank_if;

	// row of each bank.
	// the even row runs one ahead on an odd word start.
	logic [`MEMBUS_SRAM_AW-1:0] addr_eve;
	logic [`MEMBUS_SRAM_AW-1:0] addr_odd;

	// write data per lane, already swapped into bank order.
	logic [`MEMBUS_DW/2-1:0] data_eve_w;
	logic [`MEMBUS_DW/2-1:0] data_odd_w;

	// byte strobes per lane.
	logic [`MEMBUS_DW/16-1:0] wstrb_eve;
	logic [`MEMBUS_DW/16-1:0] wstrb_odd;

	// shared write enable, both banks write together.
	logic wen;

	// decoder side.
	modport src (
		output addr_eve,
		output addr_odd,
		output data_eve_w,
		output data_odd_w,
		output wstrb_eve,
		output wstrb_odd,
		output wen
	);

	// bank side.
	modport sink (
		input addr_eve,
		input addr_odd,
		input data_eve_w,
		input data_odd_w,
		input wstrb_eve,
		input wstrb_odd,
		input wen
	);

endinterface

/* common/membus_pkg.sv */
// memory bus package.
// types shared between the request decoder and the read aligner.

package membus_pkg;

	// region of a request, taken from the top address nibble.
	// only sram is backed by storage.
	typedef enum logic [1:0] {
		REGION_NONE   = 2'd0,
		REGION_SRAM   = 2'd1,
		REGION_PERIPH = 2'd2
	} region_e;

endpackage

/* common/membus_settings.svh */
// memory bus settings.
// widths and region tags shared by the decoder, banks and aligner.

`ifndef MEMBUS_SETTINGS_SVH
`define MEMBUS_SETTINGS_SVH

// row address width of each 32-bit bank.
`define MEMBUS_SRAM_AW 10

// master data width, each bank holds one half of it.
`define MEMBUS_DW 64

// top address nibble of the sram region.
`define MEMBUS_SRAM_TAG 4'h8

// top address nibble of the peripheral region.
// decoded only, nothing sits behind it yet.
`define MEMBUS_PERIPH_TAG 4'h9

`endif

/* filelist.f */
+incdir+common
common/membus_pkg.sv
common/bank_if.sv
hw/memory_bus/mem_decode.sv
hw/memory_bus/bank_sram.sv
hw/memory_bus/read_align.sv
hw/memory_bus/memory_bus.sv
tb/tb_memory_bus.sv

/* hw/memory_bus/bank_sram.sv */
// single sram bank.
// synchronous read-first memory with per-byte write enables.

`timescale 1ns/1ps

module bank_sram #(
	parameter int AW = 10,
	parameter int DW = 32
) (
	input  logic            CLK,

	input  logic [AW-1:0]   addr,
	input  logic [DW-1:0]   data_w,
	input  logic [DW/8-1:0] wstrb,
	input  logic            wen,

	output logic [DW-1:0]   data_r
);

	localparam int DEPTH = 1 << AW;
	localparam int NB    = DW / 8;

	// storage array, contents are undefined after power up.
	logic [DW-1:0] mem [DEPTH];

	// byte writes, each lane gated by its own strobe.
	always_ff @(posedge CLK) begin
		if (wen) begin
			for (int i = 0; i < NB; i++) begin
				if (wstrb[i]) begin
					mem[addr][8*i +: 8] <= data_w[8*i +: 8];
				end
			end
		end
	end

	// read port samples every cycle.
	// the old row is returned on a write to the same address.
	always_ff @(posedge CLK) begin
		data_r <= mem[addr];
	end

endmodule

/* hw/memory_bus/mem_decode.sv */
// request decoder and lane splitter.
// picks the region, splits the doubleword into bank lanes and tags the read side.

`timescale 1ns/1ps

`include "membus_settings.svh"

module mem_decode (
	input  logic                     CLK,
	input  logic                     rst,

	input  logic                     req_valid,
	input  logic [63:0]              req_addr,
	input  logic [`MEMBUS_DW-1:0]    req_data_w,
	input  logic [`MEMBUS_DW/8-1:0]  req_wstrb,
	input  logic                     req_wen,

	bank_if.src                      bank,

	output logic                     valid_q,
	output membus_pkg::region_e      region_q,
	output logic                     realign_q
);

	localparam int HW = `MEMBUS_DW / 2;
	localparam int SW = `MEMBUS_DW / 16;

	membus_pkg::region_e region;
	logic realign;
	logic is_sram;
	logic [`MEMBUS_SRAM_AW-1:0] row;
	logic [`MEMBUS_SRAM_AW-1:0] row_next;

	// region from the top nibble.
	always_comb begin
		case (req_addr[63:60])
			`MEMBUS_SRAM_TAG:   region = membus_pkg::REGION_SRAM;
			`MEMBUS_PERIPH_TAG: region = membus_pkg::REGION_PERIPH;
			default:            region = membus_pkg::REGION_NONE;
		endcase
	end

	assign is_sram = (region == membus_pkg::REGION_SRAM);

	// bit 2 set means the access starts in the odd bank.
	assign realign = req_addr[2];

	// row of the doubleword, zero outside sram.
	assign row = is_sram ? req_addr[3 +: `MEMBUS_SRAM_AW] : '0;

	// wraps at the top of the bank by width.
	assign row_next = row + 1'b1;

	// odd bank always sits on the row itself.
	// the even row only moves ahead inside sram.
	assign bank.addr_odd = row;
	assign bank.addr_eve = (realign && is_sram) ? row_next : row;

	// lanes swap when the low half lands in the odd bank.
	assign bank.data_eve_w = realign ? req_data_w[HW +: HW] : req_data_w[0 +: HW];
	assign bank.data_odd_w = realign ? req_data_w[0 +: HW]  : req_data_w[HW +: HW];

	assign bank.wstrb_eve = realign ? req_wstrb[SW +: SW] : req_wstrb[0 +: SW];
	assign bank.wstrb_odd = realign ? req_wstrb[0 +: SW]  : req_wstrb[SW +: SW];

	// peripheral and unmapped writes are dropped here.
	assign bank.wen = req_valid & req_wen & is_sram;

	// response strobe follows the request one cycle later.
	always_ff @(posedge CLK) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= req_valid;
		end
	end

	// tags for the read side, held until the next request.
	always_ff @(posedge CLK) begin
		if (rst) begin
			region_q  <= membus_pkg::REGION_NONE;
			realign_q <= 1'b0;
		end else if (req_valid) begin
			region_q  <= region;
			realign_q <= realign;
		end
	end

endmodule

/* hw/memory_bus/memory_bus.sv */
// memory bus top level.
// decodes master requests onto two 32-bit banks and returns aligned read data.

`timescale 1ns/1ps

`include "membus_settings.svh"

module memory_bus (
	input  logic                     CLK,
	input  logic                     rst,

	// request, valid for the single cycle of req_valid.
	input  logic                     req_valid,
	input  logic [63:0]              req_addr,
	input  logic [`MEMBUS_DW-1:0]    req_data_w,
	input  logic [`MEMBUS_DW/8-1:0]  req_wstrb,
	input  logic                     req_wen,

	// response, one cycle after each request.
	output logic                     rsp_valid,
	output logic [`MEMBUS_DW-1:0]    rsp_data_r
);

	localparam int HW = `MEMBUS_DW / 2;

	// tags registered alongside the bank read.
	logic                valid_q;
	membus_pkg::region_e region_q;
	logic                realign_q;

	// bank read words.
	logic [HW-1:0] data_eve_r;
	logic [HW-1:0] data_odd_r;

	bank_if bank ();

	mem_decode u_mem_decode (
		.CLK        (CLK),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_addr   (req_addr),
		.req_data_w (req_data_w),
		.req_wstrb  (req_wstrb),
		.req_wen    (req_wen),
		.bank       (bank),
		.valid_q    (valid_q),
		.region_q   (region_q),
		.realign_q  (realign_q)
	);

	// even bank, holds words with address bit 2 clear.
	bank_sram #(
		.AW (`MEMBUS_SRAM_AW),
		.DW (HW)
	) u_bank_eve (
		.CLK    (CLK),
		.addr   (bank.addr_eve),
		.data_w (bank.data_eve_w),
		.wstrb  (bank.wstrb_eve),
		.wen    (bank.wen),
		.data_r (data_eve_r)
	);

	// odd bank, holds words with address bit 2 set.
	bank_sram #(
		.AW (`MEMBUS_SRAM_AW),
		.DW (HW)
	) u_bank_odd (
		.CLK    (CLK),
		.addr   (bank.addr_odd),
		.data_w (bank.data_odd_w),
		.wstrb  (bank.wstrb_odd),
		.wen    (bank.wen),
		.data_r (data_odd_r)
	);

	read_align u_read_align (
		.valid_q    (valid_q),
		.region_q   (region_q),
		.realign_q  (realign_q),
		.data_eve_r (data_eve_r),
		.data_odd_r (data_odd_r),
		.rsp_valid  (rsp_valid),
		.rsp_data_r (rsp_data_r)
	);

endmodule

/* hw/memory_bus/read_align.sv */
// read aligner and response generator.
// undoes the lane swap, masks non-sram reads and forwards the response strobe.

`timescale 1ns/1ps

`include "membus_settings.svh"

module read_align (
	input  logic                     valid_q,
	input  membus_pkg::region_e      region_q,
	input  logic                     realign_q,

	input  logic [`MEMBUS_DW/2-1:0]  data_eve_r,
	input  logic [`MEMBUS_DW/2-1:0]  data_odd_r,

	output logic                     rsp_valid,
	output logic [`MEMBUS_DW-1:0]    rsp_data_r
);

	logic [`MEMBUS_DW-1:0] data_joined;
	logic                  is_sram_q;

	// even word is the low half on an aligned access.
	// on an odd start the odd word holds the low half.
	assign data_joined = realign_q ? {data_eve_r, data_odd_r}
	                               : {data_odd_r, data_eve_r};

	assign is_sram_q = (region_q == membus_pkg::REGION_SRAM);

	// peripheral and unmapped reads come back as zero.
	assign rsp_data_r = is_sram_q ? data_joined : '0;

	// one response per request, no back-pressure.
	assign rsp_valid = valid_q;

endmodule

/* tb/tb_memory_bus.sv */
// testbench for the memory bus.
// drives random requests and checks each response against a byte-array model.

`timescale 1ns/1ps

`include "membus_settings.svh"

module tb_memory_bus;

	localparam int AW        = `MEMBUS_SRAM_AW;
	localparam int DEPTH     = 1 << AW;
	localparam int BYTES     = 1 << (AW + 3);
	localparam int DRAIN_MAX = 16;

	logic        clk;
	logic        rst;
	logic        req_valid;
	logic [63:0] req_addr;
	logic [63:0] req_data_w;
	logic [7:0]  req_wstrb;
	logic        req_wen;
	logic        rsp_valid;
	logic [63:0] rsp_data_r;

	// model of the sram seen as one byte array.
	logic [7:0]  model_mem [BYTES];

	// expected responses, one entry per request.
	int          exp_cyc_q [$];
	logic [63:0] exp_data_q [$];
	bit          exp_chk_q [$];

	logic [31:0] lfsr_state;
	int          cyc;
	int          err_count;
	int          tests_run;
	int          tests_failed;
	bit          check_data;

	memory_bus u_memory_bus (
		.CLK        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_addr   (req_addr),
		.req_data_w (req_data_w),
		.req_wstrb  (req_wstrb),
		.req_wen    (req_wen),
		.rsp_valid  (rsp_valid),
		.rsp_data_r (rsp_data_r)
	);

	// 40 ns clock.
	always begin
		#20 clk = ~clk;
	end

	// galois lfsr, taps of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit taken.
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r[i] = lfsr_state[0];
		end
		return r;
	endfunction

	// middle address bits are don't care, so they get noise.
	function automatic logic [63:0] make_addr(input logic [3:0] nib, input logic [AW+2:0] off);
		logic [63:0] a;
		a = rand_bits(64);
		a[63:60] = nib;
		a[AW+2:0] = off;
		return a;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	// predicts the response from the old bytes, then applies the write.
	task automatic model_request(input logic [63:0] addr, input logic [63:0] data,
			input logic [7:0] strb, input logic wen);
		logic [63:0] exp;
		int base;
		int idx;
		int i;
		bit sram;
		sram = (addr[63:60] == `MEMBUS_SRAM_TAG);
		base = int'(addr[AW+2:2]) * 4;
		exp = '0;
		for (i = 0; i < 8; i++) begin
			idx = (base + i) % BYTES;
			if (sram) begin
				exp[8*i +: 8] = model_mem[idx];
				if (wen && strb[i]) begin
					model_mem[idx] = data[8*i +: 8];
				end
			end
		end
		exp_cyc_q.push_back(cyc);
		exp_data_q.push_back(exp);
		exp_chk_q.push_back(check_data);
	endtask

	// sampled on the falling edge, away from the driving edge.
	// responses are matched first, then the current request enters the model.
	always @(negedge clk) begin
		if (!rst) begin
			if (exp_cyc_q.size() > 0 && exp_cyc_q[0] == cyc - 1) begin
				if (rsp_valid !== 1'b1) begin
					$display("ERROR at %0t: no response one cycle after the request", $time);
					err_count++;
				end else if (exp_chk_q[0]) begin
					check_value("rsp_data_r", rsp_data_r, exp_data_q[0]);
				end
				exp_cyc_q.delete(0);
				exp_data_q.delete(0);
				exp_chk_q.delete(0);
			end else if (rsp_valid !== 1'b0) begin
				$display("ERROR at %0t: response seen with no request before it", $time);
				err_count++;
			end
			if (req_valid) begin
				model_request(req_addr, req_data_w, req_wstrb, req_wen);
			end
		end
		cyc++;
	end

	task automatic send_request(input logic [63:0] addr, input logic [63:0] data,
			input logic [7:0] strb, input logic wen);
		@(posedge clk);
		req_valid  <= 1'b1;
		req_addr   <= addr;
		req_data_w <= data;
		req_wstrb  <= strb;
		req_wen    <= wen;
	endtask

	// idle cycle with a write-looking payload that must be ignored.
	task automatic go_idle();
		@(posedge clk);
		req_valid  <= 1'b0;
		req_addr   <= make_addr(`MEMBUS_SRAM_TAG, rand_bits(AW + 3));
		req_data_w <= rand_bits(64);
		req_wstrb  <= 8'hff;
		req_wen    <= 1'b1;
	endtask

	task automatic maybe_idle();
		if (rand_bits(1)) begin
			go_idle();
		end
	endtask

	// waits for all outstanding responses.
	task automatic drain();
		int n;
		go_idle();
		n = 0;
		while (exp_cyc_q.size() > 0 && n < DRAIN_MAX) begin
			@(posedge clk);
			n++;
		end
		if (exp_cyc_q.size() > 0) begin
			$display("ERROR at %0t: %0d responses never arrived", $time, exp_cyc_q.size());
			err_count++;
			exp_cyc_q.delete();
			exp_data_q.delete();
			exp_chk_q.delete();
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (err_count != err_before) begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_count - err_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	initial begin
		int i;
		int e;
		logic [3:0] nib;
		logic [AW+2:0] off;
		logic [AW-1:0] row;
		logic [1:0] low;
		clk = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		req_data_w = '0;
		req_wstrb = '0;
		req_wen = 1'b0;
		lfsr_state = 32'he9cc_ca9e;
		cyc = 0;
		err_count = 0;
		tests_run = 0;
		tests_failed = 0;
		check_data = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// quiet bus, then fill the whole sram with known data.
		e = err_count;
		for (i = 0; i < 4; i++) begin
			go_idle();
			@(negedge clk);
			check_value("rsp_valid", rsp_valid, 64'd0);
		end
		for (i = 0; i < DEPTH; i++) begin
			send_request(make_addr(`MEMBUS_SRAM_TAG, {i[AW-1:0], 3'b000}), rand_bits(64),
				8'hff, 1'b1);
		end
		drain();
		check_data = 1'b1;
		end_test("reset and fill", e);

		e = err_count;
		for (i = 0; i < 200; i++) begin
			row = rand_bits(AW);
			low = rand_bits(2);
			off = {row, 1'b0, low};
			send_request(make_addr(`MEMBUS_SRAM_TAG, off), rand_bits(64), rand_bits(8), 1'b0);
			maybe_idle();
		end
		drain();
		end_test("aligned reads", e);

		// last row first, so the even row wraps to zero.
		e = err_count;
		off = {{AW{1'b1}}, 3'b100};
		send_request(make_addr(`MEMBUS_SRAM_TAG, off), rand_bits(64), 8'hff, 1'b1);
		send_request(make_addr(`MEMBUS_SRAM_TAG, off), rand_bits(64), 8'h00, 1'b0);
		send_request(make_addr(`MEMBUS_SRAM_TAG, {AW + 3{1'b0}}), rand_bits(64), 8'h00, 1'b0);
		for (i = 0; i < 200; i++) begin
			row = rand_bits(AW);
			low = rand_bits(2);
			off = {row, 1'b1, low};
			send_request(make_addr(`MEMBUS_SRAM_TAG, off), rand_bits(64), rand_bits(8),
				rand_bits(1));
			maybe_idle();
		end
		drain();
		end_test("realigned accesses", e);

		// each write is read back, the write itself returns the old bytes.
		e = err_count;
		for (i = 0; i < 150; i++) begin
			off = rand_bits(AW + 3);
			send_request(make_addr(`MEMBUS_SRAM_TAG, off), rand_bits(64), rand_bits(8), 1'b1);
			send_request(make_addr(`MEMBUS_SRAM_TAG, off), rand_bits(64), rand_bits(8), 1'b0);
			maybe_idle();
		end
		drain();
		end_test("byte strobes", e);

		e = err_count;
		for (i = 0; i < 100; i++) begin
			nib = rand_bits(4);
			if (nib == `MEMBUS_SRAM_TAG) begin
				nib = `MEMBUS_PERIPH_TAG;
			end
			off = rand_bits(AW + 3);
			send_request(make_addr(nib, off), rand_bits(64), 8'hff, 1'b1);
			send_request(make_addr(nib, off), rand_bits(64), 8'h00, 1'b0);
			send_request(make_addr(`MEMBUS_SRAM_TAG, off), rand_bits(64), 8'h00, 1'b0);
		end
		drain();
		end_test("non-sram regions", e);

		// mostly sram, no gaps between requests.
		e = err_count;
		for (i = 0; i < 400; i++) begin
			nib = rand_bits(2) == 2'd0 ? rand_bits(4) : `MEMBUS_SRAM_TAG;
			send_request(make_addr(nib, rand_bits(AW + 3)), rand_bits(64), rand_bits(8),
				rand_bits(1));
		end
		drain();
		end_test("back-to-back", e);

		$display("tests %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
